//--- source/pe_config_pkg.sv
// shared types, packet field positions, command and reply codes, FSM state enums
package pe_config_pkg;

  // plain vector types
  typedef logic [133:0] net_word_t;
  typedef logic [31:0]  conf_addr_t;
  typedef logic [31:0]  conf_data_t;
  typedef logic [3:0]   conf_en_t;
  typedef logic [47:0]  mac_t;
  typedef logic [19:0]  lb_addr_t;
  // read data in the upper half, address in the lower half
  typedef logic [63:0]  rd_entry_t;

  ////////////////////
  // packet format
  ////////////////////
  localparam logic [1:0]  TAG_START   = 2'b01;
  localparam logic [1:0]  TAG_END     = 2'b10;
  localparam logic [1:0]  TAG_BODY    = 2'b00;
  localparam int          TAG_LSB     = 132;
  localparam logic [3:0]  MASK_FULL   = 4'hf;
  // first word fields
  localparam int          CMD_LSB     = 0;
  localparam int          DST_MAC_LSB = 32;
  localparam int          SRC_MAC_LSB = 80;
  // second and later word fields
  localparam int          SEL_LSB     = 16;
  localparam int          ADDR_LSB    = 16;
  localparam int          WDATA_LSB   = 48;

  // command codes in the first word
  localparam logic [1:0]  CMD_RD_PROG = 2'd0;
  localparam logic [1:0]  CMD_WR_SEL  = 2'd1;
  localparam logic [1:0]  CMD_RD_SEL  = 2'd2;
  localparam logic [1:0]  CMD_WR_PROG = 2'd3;

  // reply ethertype and reply codes
  localparam logic [15:0] ETH_TYPE_CONF = 16'h9005;
  localparam logic [15:0] REPLY_SEL     = 16'h0012;
  localparam logic [15:0] REPLY_WR_ACK  = 16'h000c;
  localparam logic [15:0] REPLY_RDATA   = 16'h0014;

  ////////////////////
  // localbus and memory
  ////////////////////
  localparam int LB_SEL_BIT    = 16;
  localparam int LB_MEM_ADDR_W = 16;
  localparam int MEM_RD_LAT    = 2;
  localparam int RD_CNT_W      = $clog2(MEM_RD_LAT + 1);
  localparam int RD_FIFO_DEPTH = 4;
  localparam int RD_PTR_W      = $clog2(RD_FIFO_DEPTH);

  // reset values
  localparam conf_en_t CONF_EN_RST   = 4'hf;
  localparam mac_t     MAC_LOCAL_RST = 48'h1111_2222_4444;
  localparam mac_t     MAC_DST_RST   = 48'h1111_2222_3333;

  // command FSM states
  typedef enum logic [3:0] {
    S_IDLE,
    S_LB_RD_WAIT,
    S_LB_ACK,
    S_LB_WAIT_END,
    S_WR_SEL,
    S_RD_SEL,
    S_WR_PROG,
    S_RD_PROG,
    S_DISCARD
  } cmd_state_e;

  // reply FSM states
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_SEL_HEAD,
    TX_WR_HEAD,
    TX_RD_HEAD,
    TX_WORD2,
    TX_WORD3,
    TX_WORD4
  } tx_state_e;

endpackage

//--- source/conf_cmd_ctrl.sv
// command FSM: localbus access, network command decode, memory config port
`timescale 1ns/1ps

module conf_cmd_ctrl
  import pe_config_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  // localbus
  input  logic       i_cs,
  input  logic       i_wr_rd,
  input  lb_addr_t   i_address,
  input  conf_data_t i_data_in,
  output logic       o_ack_n,
  output conf_data_t o_data_out,
  // network input
  input  logic       i_net_valid,
  input  net_word_t  i_net_word,
  // memory config port
  input  conf_data_t i_conf_rdata,
  output logic       o_conf_rden,
  output logic       o_conf_wren,
  output conf_addr_t o_conf_addr,
  output conf_data_t o_conf_wdata,
  output conf_en_t   o_conf_en,
  // to read capture and reply blocks
  output logic       o_net_rd_issue,
  output logic       o_sel_req,
  output logic       o_wr_ack_req,
  output mac_t       o_reply_dst_mac,
  output mac_t       o_reply_src_mac
);

  cmd_state_e          r_state;
  logic [RD_CNT_W-1:0] r_wait_cnt;
  logic [1:0]          net_tag;
  logic                net_start;
  logic                pkt_end;

  // packet framing
  assign net_tag   = i_net_word[TAG_LSB +: 2];
  assign net_start = i_net_valid && (net_tag == TAG_START);
  // end tag, or valid dropped
  assign pkt_end   = !i_net_valid || (net_tag == TAG_END);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state         <= S_IDLE;
      r_wait_cnt      <= '0;
      o_ack_n         <= 1'b1;
      o_data_out      <= '0;
      o_conf_rden     <= 1'b0;
      o_conf_wren     <= 1'b0;
      o_conf_addr     <= '0;
      o_conf_wdata    <= '0;
      o_conf_en       <= CONF_EN_RST;
      o_net_rd_issue  <= 1'b0;
      o_sel_req       <= 1'b0;
      o_wr_ack_req    <= 1'b0;
      o_reply_dst_mac <= MAC_DST_RST;
      o_reply_src_mac <= MAC_LOCAL_RST;
    end else begin
      // strobes last one cycle
      o_conf_rden    <= 1'b0;
      o_conf_wren    <= 1'b0;
      o_net_rd_issue <= 1'b0;

      case (r_state)
        ////////////////////
        // idle, localbus first
        ////////////////////
        S_IDLE: begin
          if (!i_cs) begin
            // upper memory address bits are zero
            o_conf_addr <= conf_addr_t'(i_address[LB_MEM_ADDR_W-1:0]);
            if (i_address[LB_SEL_BIT]) begin
              // enable register window
              if (i_wr_rd) begin
                o_conf_en <= i_data_in[$bits(conf_en_t)-1:0];
              end else begin
                o_data_out <= conf_data_t'(o_conf_en);
              end
              r_state <= S_LB_ACK;
            end else if (i_wr_rd) begin
              o_conf_wren  <= 1'b1;
              o_conf_wdata <= i_data_in;
              r_state      <= S_LB_ACK;
            end else begin
              // memory read, wait for the data
              o_conf_rden <= 1'b1;
              r_wait_cnt  <= '0;
              r_state     <= S_LB_RD_WAIT;
            end
          end else if (net_start) begin
            // reply goes back with the MACs swapped
            o_reply_dst_mac <= i_net_word[SRC_MAC_LSB +: $bits(mac_t)];
            o_reply_src_mac <= i_net_word[DST_MAC_LSB +: $bits(mac_t)];
            case (i_net_word[CMD_LSB +: 2])
              CMD_WR_SEL:  r_state <= S_WR_SEL;
              CMD_RD_SEL:  r_state <= S_RD_SEL;
              CMD_WR_PROG: r_state <= S_WR_PROG;
              CMD_RD_PROG: r_state <= S_RD_PROG;
              default:     r_state <= S_DISCARD;
            endcase
          end
        end
        ////////////////////
        // localbus
        ////////////////////
        S_LB_RD_WAIT: begin
          // sample the data at the fixed memory latency
          if (r_wait_cnt == RD_CNT_W'(MEM_RD_LAT)) begin
            o_data_out <= i_conf_rdata;
            r_state    <= S_LB_ACK;
          end else begin
            r_wait_cnt <= r_wait_cnt + 1'b1;
          end
        end
        S_LB_ACK: begin
          o_ack_n <= 1'b0;
          r_state <= S_LB_WAIT_END;
        end
        S_LB_WAIT_END: begin
          // hold ack until the host lets go of cs
          if (i_cs) begin
            o_ack_n <= 1'b1;
            r_state <= S_IDLE;
          end
        end
        ////////////////////
        // network
        ////////////////////
        S_WR_SEL: begin
          if (i_net_valid) begin
            o_conf_en <= i_net_word[SEL_LSB +: $bits(conf_en_t)];
          end
          r_state <= pkt_end ? S_IDLE : S_DISCARD;
        end
        S_RD_SEL: begin
          // ask for an enable register reply
          o_sel_req <= ~o_sel_req;
          r_state   <= pkt_end ? S_IDLE : S_DISCARD;
        end
        S_WR_PROG: begin
          // one write per arriving word
          if (i_net_valid) begin
            o_conf_wren  <= 1'b1;
            o_conf_addr  <= i_net_word[ADDR_LSB +: $bits(conf_addr_t)];
            o_conf_wdata <= i_net_word[WDATA_LSB +: $bits(conf_data_t)];
          end
          if (pkt_end) begin
            o_wr_ack_req <= ~o_wr_ack_req;
            r_state      <= S_IDLE;
          end
        end
        S_RD_PROG: begin
          // single read, result goes to the capture FIFO
          if (i_net_valid) begin
            o_conf_rden    <= 1'b1;
            o_net_rd_issue <= 1'b1;
            o_conf_addr    <= i_net_word[ADDR_LSB +: $bits(conf_addr_t)];
          end
          r_state <= pkt_end ? S_IDLE : S_DISCARD;
        end
        S_DISCARD: begin
          if (pkt_end) begin
            r_state <= S_IDLE;
          end
        end
        default: begin
          r_state <= S_IDLE;
        end
      endcase
    end
  end

  // read and write strobes never overlap on the config port
  a_strobe_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_conf_wren && o_conf_rden));

  // ack only falls while the host still holds cs low
  a_ack_in_cs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(o_ack_n) |-> !i_cs);

endmodule

//--- source/rd_capture_fifo.sv
// read latency delay line and small FIFO of captured network read results
`timescale 1ns/1ps

module rd_capture_fifo
  import pe_config_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_net_rd_issue,
  input  conf_addr_t i_rd_addr,
  input  conf_data_t i_conf_rdata,
  input  logic       i_pop,
  output logic       o_empty,
  output rd_entry_t  o_entry
);

  logic [MEM_RD_LAT-1:0] r_issue_sr;
  conf_addr_t            r_addr_sr [MEM_RD_LAT];
  rd_entry_t             r_mem [RD_FIFO_DEPTH];
  logic [RD_PTR_W-1:0]   r_wr_ptr;
  logic [RD_PTR_W-1:0]   r_rd_ptr;
  logic [RD_PTR_W:0]     r_count;
  logic                  push;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  // issue strobe delay, carries control
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_issue_sr <= '0;
    end else begin
      r_issue_sr[0] <= i_net_rd_issue;
      for (int i = 1; i < MEM_RD_LAT; i++) begin
        r_issue_sr[i] <= r_issue_sr[i-1];
      end
    end
  end

  // address follows the strobe down the line
  always_ff @(posedge i_clk) begin
    r_addr_sr[0] <= i_rd_addr;
    for (int i = 1; i < MEM_RD_LAT; i++) begin
      r_addr_sr[i] <= r_addr_sr[i-1];
    end
  end

  // memory data is valid as the strobe leaves the line
  assign push    = r_issue_sr[MEM_RD_LAT-1];
  assign full    = (r_count == RD_FIFO_DEPTH);
  assign o_empty = (r_count == '0);
  assign do_push = push && !full;
  assign do_pop  = i_pop && !o_empty;
  assign o_entry = r_mem[r_rd_ptr];

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      r_mem[r_wr_ptr] <= {i_conf_rdata, r_addr_sr[MEM_RD_LAT-1]};
    end
  end

  ////////////////////
  // pointers and fill count
  ////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (do_push) begin
        r_wr_ptr <= (r_wr_ptr == RD_PTR_W'(RD_FIFO_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (do_pop) begin
        r_rd_ptr <= (r_rd_ptr == RD_PTR_W'(RD_FIFO_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // network never has more reads in flight than the FIFO holds
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    push |-> !full);

  // reply side only pops a present entry
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> !o_empty);

endmodule

//--- source/reply_tx.sv
// reply FSM building the four-word reply and acknowledge packets
`timescale 1ns/1ps

module reply_tx
  import pe_config_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_sel_req,
  input  logic      i_wr_ack_req,
  input  mac_t      i_dst_mac,
  input  mac_t      i_src_mac,
  input  conf_en_t  i_conf_en,
  input  logic      i_rd_empty,
  input  rd_entry_t i_rd_entry,
  output logic      o_rd_pop,
  output logic      o_net_valid,
  output net_word_t o_net_word
);

  tx_state_e r_state;
  // local copies of the toggle flags
  logic      r_sel_seen;
  logic      r_wr_seen;
  // word 2 source, read entry or enable register
  logic      r_is_rdata;
  logic      sel_pend;
  logic      wr_pend;
  net_word_t word2;

  // first word of every reply
  function automatic net_word_t make_head(input mac_t dst, input mac_t src,
                                          input logic [15:0] code);
    net_word_t w;
    w = {TAG_START, MASK_FULL, 128'b0};
    w[DST_MAC_LSB +: $bits(mac_t)] = dst;
    w[SRC_MAC_LSB +: $bits(mac_t)] = src;
    w[31:0] = {ETH_TYPE_CONF, code};
    return w;
  endfunction

  assign sel_pend = (i_sel_req != r_sel_seen);
  assign wr_pend  = (i_wr_ack_req != r_wr_seen);

  always_comb begin
    word2 = {TAG_BODY, MASK_FULL, 128'b0};
    if (r_is_rdata) begin
      word2[ADDR_LSB +: $bits(conf_addr_t)]  = i_rd_entry[31:0];
      word2[WDATA_LSB +: $bits(conf_data_t)] = i_rd_entry[63:32];
    end else begin
      word2[SEL_LSB +: $bits(conf_en_t)] = i_conf_en;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state     <= TX_IDLE;
      r_sel_seen  <= 1'b0;
      r_wr_seen   <= 1'b0;
      r_is_rdata  <= 1'b0;
      o_rd_pop    <= 1'b0;
      o_net_valid <= 1'b0;
      o_net_word  <= '0;
    end else begin
      o_rd_pop <= 1'b0;
      case (r_state)
        TX_IDLE: begin
          // gap cycle, then pick by priority
          o_net_valid <= 1'b0;
          if (sel_pend) begin
            r_state <= TX_SEL_HEAD;
          end else if (wr_pend) begin
            r_state <= TX_WR_HEAD;
          end else if (!i_rd_empty) begin
            r_state <= TX_RD_HEAD;
          end
        end
        TX_SEL_HEAD: begin
          o_net_valid <= 1'b1;
          o_net_word  <= make_head(i_dst_mac, i_src_mac, REPLY_SEL);
          r_sel_seen  <= i_sel_req;
          r_is_rdata  <= 1'b0;
          r_state     <= TX_WORD2;
        end
        TX_WR_HEAD: begin
          o_net_valid <= 1'b1;
          o_net_word  <= make_head(i_dst_mac, i_src_mac, REPLY_WR_ACK);
          r_wr_seen   <= i_wr_ack_req;
          r_is_rdata  <= 1'b0;
          r_state     <= TX_WORD2;
        end
        TX_RD_HEAD: begin
          o_net_valid <= 1'b1;
          o_net_word  <= make_head(i_dst_mac, i_src_mac, REPLY_RDATA);
          r_is_rdata  <= 1'b1;
          r_state     <= TX_WORD2;
        end
        TX_WORD2: begin
          o_net_word <= word2;
          // entry taken, release it
          o_rd_pop   <= r_is_rdata;
          r_state    <= TX_WORD3;
        end
        TX_WORD3: begin
          o_net_word <= {TAG_BODY, MASK_FULL, 128'd1};
          r_state    <= TX_WORD4;
        end
        TX_WORD4: begin
          o_net_word <= {TAG_END, MASK_FULL, 128'd2};
          r_state    <= TX_IDLE;
        end
        default: begin
          r_state <= TX_IDLE;
        end
      endcase
    end
  end

  // every reply is start word, two body words, end word
  a_reply_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_net_valid) |-> o_net_word[TAG_LSB +: 2] == TAG_START
      ##3 (o_net_valid && o_net_word[TAG_LSB +: 2] == TAG_END));

endmodule

//--- source/pe_config_top.sv
// top level of the PE config port: command FSM, read capture FIFO, reply FSM
`timescale 1ns/1ps

module pe_config_top
  import pe_config_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  // localbus
  input  logic       i_cs,
  input  logic       i_wr_rd,
  input  lb_addr_t   i_address,
  input  conf_data_t i_data_in,
  output logic       o_ack_n,
  output conf_data_t o_data_out,
  // network
  input  logic       i_net_valid,
  input  net_word_t  i_net_word,
  output logic       o_net_valid,
  output net_word_t  o_net_word,
  // memory config port
  output logic       o_conf_rden,
  output logic       o_conf_wren,
  output conf_addr_t o_conf_addr,
  output conf_data_t o_conf_wdata,
  input  conf_data_t i_conf_rdata,
  output conf_en_t   o_conf_en
);

  // command FSM to capture and reply
  logic      net_rd_issue;
  logic      sel_req;
  logic      wr_ack_req;
  mac_t      reply_dst_mac;
  mac_t      reply_src_mac;
  // capture FIFO to reply
  logic      rd_empty;
  rd_entry_t rd_entry;
  logic      rd_pop;

  conf_cmd_ctrl u_cmd (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_cs            (i_cs),
    .i_wr_rd         (i_wr_rd),
    .i_address       (i_address),
    .i_data_in       (i_data_in),
    .o_ack_n         (o_ack_n),
    .o_data_out      (o_data_out),
    .i_net_valid     (i_net_valid),
    .i_net_word      (i_net_word),
    .i_conf_rdata    (i_conf_rdata),
    .o_conf_rden     (o_conf_rden),
    .o_conf_wren     (o_conf_wren),
    .o_conf_addr     (o_conf_addr),
    .o_conf_wdata    (o_conf_wdata),
    .o_conf_en       (o_conf_en),
    .o_net_rd_issue  (net_rd_issue),
    .o_sel_req       (sel_req),
    .o_wr_ack_req    (wr_ack_req),
    .o_reply_dst_mac (reply_dst_mac),
    .o_reply_src_mac (reply_src_mac)
  );

  // read address rides along with the issue strobe
  rd_capture_fifo u_rdfifo (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_net_rd_issue (net_rd_issue),
    .i_rd_addr      (o_conf_addr),
    .i_conf_rdata   (i_conf_rdata),
    .i_pop          (rd_pop),
    .o_empty        (rd_empty),
    .o_entry        (rd_entry)
  );

  reply_tx u_tx (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_sel_req    (sel_req),
    .i_wr_ack_req (wr_ack_req),
    .i_dst_mac    (reply_dst_mac),
    .i_src_mac    (reply_src_mac),
    .i_conf_en    (o_conf_en),
    .i_rd_empty   (rd_empty),
    .i_rd_entry   (rd_entry),
    .o_rd_pop     (rd_pop),
    .o_net_valid  (o_net_valid),
    .o_net_word   (o_net_word)
  );

endmodule

//--- verification/tb_pe_config.sv
// testbench for the PE config port with clock, reset, memory model, directed tests and report
`timescale 1ns/1ps

module tb_pe_config
  import pe_config_pkg::*;
();

  localparam int       TIMEOUT      = 200;
  localparam int       MASK_LSB     = 128;
  localparam int       MEM_WORDS    = 256;
  localparam lb_addr_t LB_SEL_ADDR  = lb_addr_t'(1 << LB_SEL_BIT);
  // address bits above the enable select, dropped on the way to memory
  localparam lb_addr_t LB_HIGH_BITS = 20'he0000;
  // host side and PE side MACs
  // PE MAC differs from the reset value
  localparam mac_t     HOST_MAC     = 48'h0200_00ab_cdef;
  localparam mac_t     PE_MAC       = 48'h0200_00c0_ffee;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_cs;
  logic       i_wr_rd;
  lb_addr_t   i_address;
  conf_data_t i_data_in;
  logic       o_ack_n;
  conf_data_t o_data_out;
  logic       i_net_valid;
  net_word_t  i_net_word;
  logic       o_net_valid;
  net_word_t  o_net_word;
  logic       o_conf_rden;
  logic       o_conf_wren;
  conf_addr_t o_conf_addr;
  conf_data_t o_conf_wdata;
  conf_data_t i_conf_rdata = '0;
  conf_en_t   o_conf_en;

  // memory model
  conf_data_t mem [MEM_WORDS];
  conf_data_t rd_pipe [MEM_RD_LAT];

  // packet buffers
  net_word_t  pkt [16];
  net_word_t  rx [4];

  integer     seed;
  int         checks;
  int         errors;
  int         timeouts;
  // expected enable register level
  conf_en_t   exp_en;

  pe_config_top dut0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cs         (i_cs),
    .i_wr_rd      (i_wr_rd),
    .i_address    (i_address),
    .i_data_in    (i_data_in),
    .o_ack_n      (o_ack_n),
    .o_data_out   (o_data_out),
    .i_net_valid  (i_net_valid),
    .i_net_word   (i_net_word),
    .o_net_valid  (o_net_valid),
    .o_net_word   (o_net_word),
    .o_conf_rden  (o_conf_rden),
    .o_conf_wren  (o_conf_wren),
    .o_conf_addr  (o_conf_addr),
    .o_conf_wdata (o_conf_wdata),
    .i_conf_rdata (i_conf_rdata),
    .o_conf_en    (o_conf_en)
  );

  // 40 ns clock
  always #20 i_clk = ~i_clk;

  ////////////////////
  // memory model
  ////////////////////
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      // fill pattern from the whole address
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= {8'hc3, 8'(i), 8'h3c, 8'(~i)};
      end
      for (int i = 0; i < MEM_RD_LAT; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      if (o_conf_wren || o_conf_rden) begin
        // accesses in these tests all land inside the model
        check_value("conf addr upper bits", '0, o_conf_addr[31:8]);
      end
      if (o_conf_wren) begin
        mem[o_conf_addr[7:0]] <= o_conf_wdata;
      end
      if (o_conf_rden) begin
        rd_pipe[0] <= mem[o_conf_addr[7:0]];
      end
      for (int i = 1; i < MEM_RD_LAT; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  // read data valid MEM_RD_LAT cycles after the strobe
  always @(negedge i_clk) begin
    i_conf_rdata <= rd_pipe[MEM_RD_LAT-1];
  end

  ////////////////////
  // helpers
  ////////////////////
  task automatic check_value(input string name, input logic [133:0] expected,
                             input logic [133:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // wait for o_ack_n to reach a level and count the cycles
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    while (o_ack_n !== level && cycles < TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (o_ack_n !== level) begin
      timeouts++;
      $display("ERROR o_ack_n did not go to %b within %0d cycles", level, TIMEOUT);
    end
  endtask

  // one localbus access with checks on ack timing and release
  task automatic lb_access(input string name, input logic wr, input lb_addr_t addr,
                           input conf_data_t wdata, input int exp_lat,
                           output conf_data_t rdata);
    int cycles;
    @(negedge i_clk);
    i_cs      = 1'b0;
    i_wr_rd   = wr;
    i_address = addr;
    i_data_in = wdata;
    wait_ack(1'b0, cycles);
    check_value({name, " ack latency"}, exp_lat, cycles);
    rdata = o_data_out;
    // ack must hold while cs stays low
    @(negedge i_clk);
    check_value({name, " ack held"}, 1'b0, o_ack_n);
    i_cs = 1'b1;
    wait_ack(1'b1, cycles);
    check_value({name, " ack release"}, 1, cycles);
    i_wr_rd = 1'b0;
  endtask

  function automatic net_word_t cmd_word(input logic [1:0] cmd);
    net_word_t w;
    w = {TAG_START, MASK_FULL, 128'b0};
    w[CMD_LSB +: 2] = cmd;
    w[DST_MAC_LSB +: $bits(mac_t)] = PE_MAC;
    w[SRC_MAC_LSB +: $bits(mac_t)] = HOST_MAC;
    return w;
  endfunction

  function automatic net_word_t body_word(input logic [1:0] tag, input conf_addr_t addr,
                                          input conf_data_t data);
    net_word_t w;
    w = {tag, MASK_FULL, 128'b0};
    w[ADDR_LSB +: $bits(conf_addr_t)]  = addr;
    w[WDATA_LSB +: $bits(conf_data_t)] = data;
    return w;
  endfunction

  // back to back words and then valid drops
  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++) begin
      @(negedge i_clk);
      i_net_valid = 1'b1;
      i_net_word  = pkt[i];
    end
    @(negedge i_clk);
    i_net_valid = 1'b0;
    i_net_word  = '0;
  endtask

  task automatic capture_reply(input string name);
    int cycles;
    cycles = 0;
    for (int i = 0; i < 4; i++) begin
      rx[i] = '0;
    end
    while (o_net_valid !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (o_net_valid !== 1'b1) begin
      timeouts++;
      $display("ERROR no reply packet for %s within %0d cycles", name, TIMEOUT);
    end else begin
      rx[0] = o_net_word;
      // three more valid words follow the head
      for (int i = 1; i < 4; i++) begin
        @(negedge i_clk);
        check_value({name, " word valid"}, 1'b1, o_net_valid);
        rx[i] = o_net_word;
      end
      @(negedge i_clk);
      check_value({name, " idle after reply"}, 1'b0, o_net_valid);
    end
  endtask

  task automatic check_reply(input string name, input logic [15:0] code,
                             input net_word_t exp_w2);
    check_value({name, " head tag"}, TAG_START, rx[0][TAG_LSB +: 2]);
    check_value({name, " head mask"}, MASK_FULL, rx[0][MASK_LSB +: 4]);
    // MACs come back swapped
    check_value({name, " dst mac"}, HOST_MAC, rx[0][DST_MAC_LSB +: $bits(mac_t)]);
    check_value({name, " src mac"}, PE_MAC, rx[0][SRC_MAC_LSB +: $bits(mac_t)]);
    check_value({name, " ethertype"}, ETH_TYPE_CONF, rx[0][31:16]);
    check_value({name, " reply code"}, code, rx[0][15:0]);
    check_value({name, " word 2"}, exp_w2, rx[1]);
    check_value({name, " word 3"}, {TAG_BODY, MASK_FULL, 128'd1}, rx[2]);
    check_value({name, " word 4"}, {TAG_END, MASK_FULL, 128'd2}, rx[3]);
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic idle_after_reset();
    check_value("reset ack", 1'b1, o_ack_n);
    check_value("reset rden", 1'b0, o_conf_rden);
    check_value("reset conf en", CONF_EN_RST, o_conf_en);
    repeat (20) begin
      @(negedge i_clk);
      check_value("idle net valid", 1'b0, o_net_valid);
      check_value("idle wren", 1'b0, o_conf_wren);
    end
  endtask

  task automatic lb_enable_access();
    conf_data_t rd;
    lb_access("lb sel read reset", 1'b0, LB_SEL_ADDR, '0, 2, rd);
    check_value("lb sel read reset", CONF_EN_RST, rd);
    exp_en = 4'h5;
    lb_access("lb sel write", 1'b1, LB_SEL_ADDR, 32'(exp_en), 2, rd);
    check_value("lb sel write level", exp_en, o_conf_en);
    lb_access("lb sel read back", 1'b0, LB_SEL_ADDR, '0, 2, rd);
    check_value("lb sel read back", exp_en, rd);
  endtask

  task automatic lb_memory_access();
    conf_data_t data [4];
    conf_data_t rd;
    lb_addr_t   addr;
    for (int i = 0; i < 4; i++) begin
      addr    = LB_HIGH_BITS | lb_addr_t'(16 + 37 * i);
      data[i] = $random(seed);
      lb_access("lb mem write", 1'b1, addr, data[i], 2, rd);
      check_value("lb mem write model", data[i], mem[addr[7:0]]);
    end
    for (int i = 0; i < 4; i++) begin
      addr = LB_HIGH_BITS | lb_addr_t'(16 + 37 * i);
      lb_access("lb mem read", 1'b0, addr, '0, MEM_RD_LAT + 3, rd);
      check_value("lb mem read data", data[i], rd);
    end
  endtask

  task automatic net_enable_cmds();
    net_word_t w2;
    exp_en = 4'ha;
    pkt[0] = cmd_word(CMD_WR_SEL);
    pkt[1] = body_word(TAG_END, '0, '0);
    pkt[1][SEL_LSB +: $bits(conf_en_t)] = exp_en;
    send_packet(2);
    check_value("net sel write level", exp_en, o_conf_en);
    pkt[0] = cmd_word(CMD_RD_SEL);
    pkt[1] = body_word(TAG_END, '0, '0);
    send_packet(2);
    capture_reply("net sel read");
    w2 = {TAG_BODY, MASK_FULL, 128'b0};
    w2[SEL_LSB +: $bits(conf_en_t)] = exp_en;
    check_reply("net sel read", REPLY_SEL, w2);
  endtask

  task automatic net_prog_write();
    conf_data_t data [3];
    conf_data_t rd;
    net_word_t  w2;
    pkt[0] = cmd_word(CMD_WR_PROG);
    for (int i = 0; i < 3; i++) begin
      data[i]  = $random(seed);
      pkt[i+1] = body_word((i == 2) ? TAG_END : TAG_BODY, 32'h80 + 5 * i, data[i]);
    end
    send_packet(4);
    capture_reply("net prog write ack");
    // ack carries the enable register in word 2
    w2 = {TAG_BODY, MASK_FULL, 128'b0};
    w2[SEL_LSB +: $bits(conf_en_t)] = exp_en;
    check_reply("net prog write ack", REPLY_WR_ACK, w2);
    for (int i = 0; i < 3; i++) begin
      check_value("net prog write model", data[i], mem[8'h80 + 5 * i]);
    end
    lb_access("net prog write lb read", 1'b0, 20'h85, '0, MEM_RD_LAT + 3, rd);
    check_value("net prog write lb read", data[1], rd);
  endtask

  task automatic net_prog_read();
    conf_data_t data;
    conf_data_t rd;
    net_word_t  w2;
    data = $random(seed);
    lb_access("net prog read preload", 1'b1, 20'h5a, data, 2, rd);
    pkt[0] = cmd_word(CMD_RD_PROG);
    pkt[1] = body_word(TAG_END, 32'h5a, '0);
    send_packet(2);
    capture_reply("net prog read");
    w2 = {TAG_BODY, MASK_FULL, 128'b0};
    w2[ADDR_LSB +: $bits(conf_addr_t)]  = 32'h5a;
    w2[WDATA_LSB +: $bits(conf_data_t)] = data;
    check_reply("net prog read", REPLY_RDATA, w2);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    seed        = 20771;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    exp_en      = CONF_EN_RST;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_cs        = 1'b1;
    i_wr_rd     = 1'b0;
    i_address   = '0;
    i_data_in   = '0;
    i_net_valid = 1'b0;
    i_net_word  = '0;
    repeat (16) @(negedge i_clk);
    i_rst_n = 1'b1;

    idle_after_reset();
    lb_enable_access();
    lb_memory_access();
    net_enable_cmds();
    net_prog_write();
    net_prog_read();
    repeat (4) @(negedge i_clk);

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
source/pe_config_pkg.sv
source/conf_cmd_ctrl.sv
source/rd_capture_fifo.sv
source/reply_tx.sv
source/pe_config_top.sv
verification/tb_pe_config.sv

//--- Bender.yml
package:
  name: pe_config

sources:
  - files:
      - source/pe_config_pkg.sv
      - source/conf_cmd_ctrl.sv
      - source/rd_capture_fifo.sv
      - source/reply_tx.sv
      - source/pe_config_top.sv
  - target: simulation
    files:
      - verification/tb_pe_config.sv
